/* list.f */
+incdir+logic
logic/ctrlPkg.sv
logic/instructionDecoder.sv
logic/dwellTimer.sv
logic/stateSequencer.sv
logic/controlEncoder.sv
logic/controlUnit.sv
verif/controlUnitTb.sv

/* logic/controlEncoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_consts.svh"

module controlEncoder (
    input  var ctrlPkg::ctrlState    state,
    output logic                     MemWrite,
    output logic                     PCWrite,
    output logic                     MemRead,
    output logic                     IRWrite,
    output logic                     RegWrite,
    output logic                     ALUSrcA,
    output logic                     EPCWrite,
    output logic                     IorD,
    output logic                     HIWrite,
    output logic                     LOWrite,
    output logic                     DivMult,
    output logic                     ALUoutWrite,
    output logic                     ExceptionOcurred,
    output logic [`SEL_W-1:0]        MemToReg,
    output logic [`SEL_W-1:0]        RegDest,
    output logic [`SEL_W-1:0]        WriteSrc,
    output logic [`SEL_W-1:0]        PCSource,
    output logic [`SEL_W-1:0]        ALUSrcB,
    output logic [`SEL_W-1:0]        ShiftSourceA,
    output logic [`SEL_W-1:0]        ShiftSourceB,
    output ctrlPkg::aluOp            ALUControl,
    output ctrlPkg::shiftOp          ShiftControl,
    output ctrlPkg::excCause         Exception
);

    always_comb
    begin
        MemWrite = 1'b0;
        PCWrite = 1'b0;
        MemRead = 1'b0;
        IRWrite = 1'b0;
        RegWrite = 1'b0;
        ALUSrcA = 1'b0;
        EPCWrite = 1'b0;
        IorD = 1'b0;
        HIWrite = 1'b0;
        LOWrite = 1'b0;
        DivMult = 1'b0;
        ALUoutWrite = 1'b0;
        ExceptionOcurred = 1'b0;
        MemToReg = '0;
        RegDest = '0;
        WriteSrc = '0;
        PCSource = '0;
        ALUSrcB = '0;
        ShiftSourceA = '0;
        ShiftSourceB = '0;
        ALUControl = ctrlPkg::aluLoad;
        ShiftControl = ctrlPkg::shIdle;
        Exception = ctrlPkg::excNone;

        case (state)
            ctrlPkg::stReset:
            begin
                // Load $29 with its boot value
                RegWrite = 1'b1;
                RegDest = 4'd3;
                MemToReg = 4'd2;
            end
            // Memory addressed by PC
            ctrlPkg::stFetch: MemRead = 1'b1;
            ctrlPkg::stPcInc:
            begin
                // PC + 4 straight back into PC
                ALUSrcB = 4'd1;
                ALUControl = ctrlPkg::aluAdd;
                PCWrite = 1'b1;
            end
            ctrlPkg::stDecode: IRWrite = 1'b1;
            // Register-register ALU ops, A against B
            ctrlPkg::stAdd,
            ctrlPkg::stSub,
            ctrlPkg::stAnd,
            ctrlPkg::stSlt:
            begin
                ALUSrcA = 1'b1;
                case (state)
                    ctrlPkg::stAdd: ALUControl = ctrlPkg::aluAdd;
                    ctrlPkg::stSub: ALUControl = ctrlPkg::aluSub;
                    ctrlPkg::stAnd: ALUControl = ctrlPkg::aluAnd;
                    default:        ALUControl = ctrlPkg::aluCmp;
                endcase
            end
            ctrlPkg::stMult,
            ctrlPkg::stDiv:
            begin
                ALUSrcA = 1'b1;
                HIWrite = 1'b1;
                LOWrite = 1'b1;
                // 1 selects the multiplier
                DivMult = (state == ctrlPkg::stMult);
            end
            ctrlPkg::stJr:
            begin
                // Pass rs through to PC
                ALUSrcA = 1'b1;
                PCSource = 4'd1;
                PCWrite = 1'b1;
            end
            ctrlPkg::stSavePc:
            begin
                PCSource = 4'd1;
                PCWrite = 1'b1;
            end
            ctrlPkg::stLoadShift:
            begin
                // Shift amount comes from shamt
                ALUSrcA = 1'b1;
                ShiftControl = ctrlPkg::shLoad;
            end
            ctrlPkg::stSll: ShiftControl = ctrlPkg::shLeft;
            ctrlPkg::stSra: ShiftControl = ctrlPkg::shRightArith;
            ctrlPkg::stMfhi: RegDest = 4'd1;
            ctrlPkg::stMflo:
            begin
                RegDest = 4'd1;
                WriteSrc = 4'd2;
            end
            ctrlPkg::stSaveRegRd:
            begin
                RegWrite = 1'b1;
                RegDest = 4'd1;
                WriteSrc = 4'd1;
            end
            ctrlPkg::stLoadLui:
            begin
                // Immediate on the amount input
                ShiftSourceB = 4'd1;
                ShiftControl = ctrlPkg::shLoad;
            end
            ctrlPkg::stLui:
            begin
                ShiftSourceA = 4'd1;
                ShiftControl = ctrlPkg::shLeft;
            end
            ctrlPkg::stSaveRegRt:
            begin
                RegWrite = 1'b1;
                WriteSrc = 4'd1;
            end
            // Base plus sign-extended offset
            ctrlPkg::stAddi,
            ctrlPkg::stMemCalc,
            ctrlPkg::stReadMem,
            ctrlPkg::stSw:
            begin
                ALUSrcA = 1'b1;
                ALUSrcB = 4'd2;
                ALUControl = ctrlPkg::aluAdd;
                IorD = (state == ctrlPkg::stReadMem) || (state == ctrlPkg::stSw);
                MemWrite = (state == ctrlPkg::stSw);
            end
            ctrlPkg::stLw:
            begin
                // Memory word into rt
                IorD = 1'b1;
                MemToReg = 4'd1;
                RegWrite = 1'b1;
            end
            ctrlPkg::stInvalidTrap,
            ctrlPkg::stOverflowTrap,
            ctrlPkg::stDivZeroTrap:
            begin
                // EPC gets PC - 4 which points at the faulting instruction
                EPCWrite = 1'b1;
                ALUSrcB = 4'd1;
                ALUControl = ctrlPkg::aluSub;
                RegDest = 4'd3;
                PCSource = 4'd3;
                case (state)
                    ctrlPkg::stInvalidTrap:  Exception = ctrlPkg::excInvalidOp;
                    ctrlPkg::stOverflowTrap: Exception = ctrlPkg::excOverflow;
                    default:                 Exception = ctrlPkg::excDivByZero;
                endcase
            end
            ctrlPkg::stExcVector:
            begin
                // Jump to the handler address
                RegDest = 4'd3;
                PCSource = 4'd3;
                PCWrite = 1'b1;
                ExceptionOcurred = 1'b1;
            end
            // divm keeps the defaults
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* logic/controlUnit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_consts.svh"

module controlUnit (
    input  wire                      clk,
    input  wire                      reset,
    input  wire [5:0]                opcode,
    input  wire [5:0]                funct,
    input  wire                      aluOverflow,
    input  wire                      multOverflow,
    input  wire                      divByZero,
    output logic                     MemWrite,
    output logic                     PCWrite,
    output logic                     MemRead,
    output logic                     IRWrite,
    output logic                     RegWrite,
    output logic                     ALUSrcA,
    output logic                     EPCWrite,
    output logic                     IorD,
    output logic                     HIWrite,
    output logic                     LOWrite,
    output logic                     DivMult,
    output logic                     ALUoutWrite,
    output logic                     ExceptionOcurred,
    output logic [`SEL_W-1:0]        MemToReg,
    output logic [`SEL_W-1:0]        RegDest,
    output logic [`SEL_W-1:0]        WriteSrc,
    output logic [`SEL_W-1:0]        PCSource,
    output logic [`SEL_W-1:0]        ALUSrcB,
    output logic [`SEL_W-1:0]        ShiftSourceA,
    output logic [`SEL_W-1:0]        ShiftSourceB,
    output ctrlPkg::aluOp            ALUControl,
    output ctrlPkg::shiftOp          ShiftControl,
    output ctrlPkg::excCause         Exception
);

    ctrlPkg::instrClass instClass;
    ctrlPkg::ctrlState  state;
    logic               last;

    // IR fields to instruction class
    instructionDecoder u_instructionDecoder (
        .opcode    (opcode),
        .funct     (funct),
        .instClass (instClass)
    );

    // Per-state cycle budget
    dwellTimer u_dwellTimer (
        .clk   (clk),
        .reset (reset),
        .state (state),
        .last  (last)
    );

    stateSequencer u_stateSequencer (
        .clk          (clk),
        .reset        (reset),
        .instClass    (instClass),
        .last         (last),
        .aluOverflow  (aluOverflow),
        .multOverflow (multOverflow),
        .divByZero    (divByZero),
        .state        (state)
    );

    // State to datapath controls
    controlEncoder u_controlEncoder (
        .state            (state),
        .MemWrite         (MemWrite),
        .PCWrite          (PCWrite),
        .MemRead          (MemRead),
        .IRWrite          (IRWrite),
        .RegWrite         (RegWrite),
        .ALUSrcA          (ALUSrcA),
        .EPCWrite         (EPCWrite),
        .IorD             (IorD),
        .HIWrite          (HIWrite),
        .LOWrite          (LOWrite),
        .DivMult          (DivMult),
        .ALUoutWrite      (ALUoutWrite),
        .ExceptionOcurred (ExceptionOcurred),
        .MemToReg         (MemToReg),
        .RegDest          (RegDest),
        .WriteSrc         (WriteSrc),
        .PCSource         (PCSource),
        .ALUSrcB          (ALUSrcB),
        .ShiftSourceA     (ShiftSourceA),
        .ShiftSourceB     (ShiftSourceB),
        .ALUControl       (ALUControl),
        .ShiftControl     (ShiftControl),
        .Exception        (Exception)
    );

endmodule

`default_nettype wire

/* logic/ctrlPkg.sv */
`default_nettype none

package ctrlPkg;

    // Sequencer states
    typedef enum logic [5:0] {
        stReset,
        stFetch,
        stPcInc,
        stDecode,
        stSlt,
        stSub,
        stAdd,
        stAnd,
        stMfhi,
        stMflo,
        stJr,
        stSavePc,
        stLoadShift,
        stSll,
        stSra,
        stSaveRegRd,
        stMult,
        stDiv,
        stDivm,
        stAddi,
        stLoadLui,
        stLui,
        stSaveRegRt,
        stMemCalc,
        stSw,
        stReadMem,
        stLw,
        stInvalidTrap,
        stOverflowTrap,
        stDivZeroTrap,
        stExcVector
    } ctrlState;

    // One class per supported instruction
    typedef enum logic [4:0] {
        icInvalid,
        icAdd, icSub, icAnd, icSlt,
        icMfhi, icMflo, icJr,
        icSll, icSra,
        icMult, icDiv, icDivm,
        icAddi, icLui, icLw, icSw
    } instrClass;

    // ALU function codes
    typedef enum logic [2:0] {
        aluLoad, aluAdd, aluSub, aluAnd, aluAdd1, aluNot, aluXor, aluCmp
    } aluOp;

    // Shifter commands
    typedef enum logic [2:0] {
        shIdle, shLoad, shLeft, shRightLogic, shRightArith
    } shiftOp;

    // Cause code reported alongside EPC
    typedef enum logic [3:0] {
        excNone = 4'd0,
        excInvalidOp = 4'd1,
        excOverflow = 4'd2,
        excDivByZero = 4'd3
    } excCause;

endpackage

`default_nettype wire

/* logic/ctrl_consts.svh */
`ifndef CTRL_CONSTS_SVH
`define CTRL_CONSTS_SVH

// Primary opcodes
`define OP_RTYPE    6'd0
`define OP_ADDI     6'd8
`define OP_LUI      6'd15
`define OP_LW       6'd35
`define OP_SW       6'd43

// R-type funct field
`define FN_ADD      6'd32
`define FN_SUB      6'd34
`define FN_AND      6'd36
`define FN_SLT      6'd42
`define FN_MFHI     6'd16
`define FN_MFLO     6'd18
`define FN_JR       6'd8
`define FN_SLL      6'd0
`define FN_SRA      6'd3
`define FN_MULT     6'd24
`define FN_DIV      6'd26
`define FN_DIVM     6'd5

// Datapath mux select width
`define SEL_W       4

// Dwell counter wide enough for DWELL_MULDIV
`define DWELL_W     6

// Cycles spent per state
`define DWELL_ONE       6'd1
`define DWELL_SHORT     6'd2
`define DWELL_MULDIV    6'd34
`define DWELL_TRAP      6'd6

`endif

/* logic/dwellTimer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_consts.svh"

module dwellTimer (
    input  wire                      clk,
    input  wire                      reset,
    input  var ctrlPkg::ctrlState    state,
    output logic                     last
);

    ctrlPkg::ctrlState      prevState;
    logic [`DWELL_W-1:0]    count;
    logic [`DWELL_W-1:0]    elapsed;
    logic [`DWELL_W-1:0]    dwell;

    // Cycles each state occupies before it may advance
    always_comb
    begin
        case (state)
            ctrlPkg::stReset,
            ctrlPkg::stFetch,
            ctrlPkg::stLoadShift,
            ctrlPkg::stSll,
            ctrlPkg::stSra,
            ctrlPkg::stLoadLui,
            ctrlPkg::stLui,
            ctrlPkg::stReadMem,
            ctrlPkg::stLw,
            ctrlPkg::stExcVector:   dwell = `DWELL_SHORT;
            ctrlPkg::stMult,
            ctrlPkg::stDiv,
            ctrlPkg::stDivm:        dwell = `DWELL_MULDIV;
            ctrlPkg::stInvalidTrap,
            ctrlPkg::stOverflowTrap,
            ctrlPkg::stDivZeroTrap: dwell = `DWELL_TRAP;
            default:                dwell = `DWELL_ONE;
        endcase
    end

    // Fresh state counts as its first cycle
    assign elapsed = (state != prevState) ? '0 : count;
    assign last = (elapsed == dwell - 1'b1);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            prevState <= ctrlPkg::stReset;
            count <= '0;
        end
        else
        begin
            prevState <= state;
            count <= elapsed + 1'b1;
        end
    end

    // Longest dwell is the mult/div run
    assert property (@(posedge clk) disable iff (reset) !last [*34] |=> last);

endmodule

`default_nettype wire

/* logic/instructionDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_consts.svh"

module instructionDecoder (
    input  wire [5:0]                opcode,
    input  wire [5:0]                funct,
    output ctrlPkg::instrClass       instClass
);

    always_comb
    begin
        // Anything not matched below traps as invalid
        instClass = ctrlPkg::icInvalid;
        case (opcode)
            `OP_RTYPE:
            begin
                // R-type picks the class from funct
                case (funct)
                    `FN_ADD:  instClass = ctrlPkg::icAdd;
                    `FN_SUB:  instClass = ctrlPkg::icSub;
                    `FN_AND:  instClass = ctrlPkg::icAnd;
                    `FN_SLT:  instClass = ctrlPkg::icSlt;
                    `FN_MFHI: instClass = ctrlPkg::icMfhi;
                    `FN_MFLO: instClass = ctrlPkg::icMflo;
                    `FN_JR:   instClass = ctrlPkg::icJr;
                    `FN_SLL:  instClass = ctrlPkg::icSll;
                    `FN_SRA:  instClass = ctrlPkg::icSra;
                    `FN_MULT: instClass = ctrlPkg::icMult;
                    `FN_DIV:  instClass = ctrlPkg::icDiv;
                    `FN_DIVM: instClass = ctrlPkg::icDivm;
                    default:  instClass = ctrlPkg::icInvalid;
                endcase
            end
            `OP_ADDI: instClass = ctrlPkg::icAddi;
            `OP_LUI:  instClass = ctrlPkg::icLui;
            // Loads and stores kept apart so memory calc can split
            `OP_LW:   instClass = ctrlPkg::icLw;
            `OP_SW:   instClass = ctrlPkg::icSw;
            // Branches, byte accesses and jumps land here
            default:  instClass = ctrlPkg::icInvalid;
        endcase
    end

endmodule

`default_nettype wire

/* logic/stateSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module stateSequencer (
    input  wire                      clk,
    input  wire                      reset,
    input  var ctrlPkg::instrClass   instClass,
    input  wire                      last,
    input  wire                      aluOverflow,
    input  wire                      multOverflow,
    input  wire                      divByZero,
    output ctrlPkg::ctrlState        state
);

    ctrlPkg::ctrlState nextState;
    logic              inTrapPath;
    logic              inMulDiv;

    // Reset and exception handling ignore overflow
    assign inTrapPath = (state == ctrlPkg::stReset) ||
                        (state == ctrlPkg::stInvalidTrap) ||
                        (state == ctrlPkg::stOverflowTrap) ||
                        (state == ctrlPkg::stDivZeroTrap) ||
                        (state == ctrlPkg::stExcVector);
    assign inMulDiv = (state == ctrlPkg::stMult) ||
                      (state == ctrlPkg::stDiv) ||
                      (state == ctrlPkg::stDivm);

    always_comb
    begin
        nextState = state;
        if (last)
        begin
            case (state)
                ctrlPkg::stReset:     nextState = ctrlPkg::stFetch;
                ctrlPkg::stFetch:     nextState = ctrlPkg::stPcInc;
                ctrlPkg::stPcInc:     nextState = ctrlPkg::stDecode;
                ctrlPkg::stDecode:
                begin
                    // Dispatch on decoded class
                    case (instClass)
                        ctrlPkg::icAdd:  nextState = ctrlPkg::stAdd;
                        ctrlPkg::icSub:  nextState = ctrlPkg::stSub;
                        ctrlPkg::icAnd:  nextState = ctrlPkg::stAnd;
                        ctrlPkg::icSlt:  nextState = ctrlPkg::stSlt;
                        ctrlPkg::icMfhi: nextState = ctrlPkg::stMfhi;
                        ctrlPkg::icMflo: nextState = ctrlPkg::stMflo;
                        ctrlPkg::icJr:   nextState = ctrlPkg::stJr;
                        ctrlPkg::icSll,
                        ctrlPkg::icSra:  nextState = ctrlPkg::stLoadShift;
                        ctrlPkg::icMult: nextState = ctrlPkg::stMult;
                        ctrlPkg::icDiv:  nextState = ctrlPkg::stDiv;
                        ctrlPkg::icDivm: nextState = ctrlPkg::stDivm;
                        ctrlPkg::icAddi: nextState = ctrlPkg::stAddi;
                        ctrlPkg::icLui:  nextState = ctrlPkg::stLoadLui;
                        ctrlPkg::icLw,
                        ctrlPkg::icSw:   nextState = ctrlPkg::stMemCalc;
                        default:         nextState = ctrlPkg::stInvalidTrap;
                    endcase
                end
                // ALU ops and HI/LO moves write rd next
                ctrlPkg::stAdd,
                ctrlPkg::stSub,
                ctrlPkg::stAnd,
                ctrlPkg::stSlt,
                ctrlPkg::stMfhi,
                ctrlPkg::stMflo,
                ctrlPkg::stSll,
                ctrlPkg::stSra:       nextState = ctrlPkg::stSaveRegRd;
                ctrlPkg::stJr:        nextState = ctrlPkg::stSavePc;
                // Direction picked once the shifter is loaded
                ctrlPkg::stLoadShift:
                    nextState = (instClass == ctrlPkg::icSra) ? ctrlPkg::stSra
                                                              : ctrlPkg::stSll;
                ctrlPkg::stAddi,
                ctrlPkg::stLui:       nextState = ctrlPkg::stSaveRegRt;
                ctrlPkg::stLoadLui:   nextState = ctrlPkg::stLui;
                // Store or read once the address is ready
                ctrlPkg::stMemCalc:
                    nextState = (instClass == ctrlPkg::icSw) ? ctrlPkg::stSw
                                                             : ctrlPkg::stReadMem;
                ctrlPkg::stReadMem:   nextState = ctrlPkg::stLw;
                ctrlPkg::stInvalidTrap,
                ctrlPkg::stOverflowTrap,
                ctrlPkg::stDivZeroTrap: nextState = ctrlPkg::stExcVector;
                // Everything else ends the instruction
                default:              nextState = ctrlPkg::stFetch;
            endcase
        end
        // Zero divisor aborts the HI/LO run at once
        if (inMulDiv && divByZero)
        begin
            nextState = ctrlPkg::stDivZeroTrap;
        end
        // Overflow wins over everything outside the trap path
        if (!inTrapPath && (aluOverflow || multOverflow))
        begin
            nextState = ctrlPkg::stOverflowTrap;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= ctrlPkg::stReset;
        end
        else
        begin
            state <= nextState;
        end
    end

    // Decode always hands over to an execute or trap state
    assert property (@(posedge clk) disable iff (reset)
        state == ctrlPkg::stDecode |=>
            !(state inside {ctrlPkg::stDecode, ctrlPkg::stFetch}));

endmodule

`default_nettype wire

/* verif/controlUnitTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_consts.svh"

module controlUnitTb;

    // Instruction kinds presented at each fetch
    localparam int kAdd = 0;
    localparam int kSub = 1;
    localparam int kAnd = 2;
    localparam int kSlt = 3;
    localparam int kMfhi = 4;
    localparam int kMflo = 5;
    localparam int kAddi = 6;
    localparam int kSll = 7;
    localparam int kSra = 8;
    localparam int kLui = 9;
    localparam int kLw = 10;
    localparam int kSw = 11;
    localparam int kMult = 12;
    localparam int kDivm = 13;
    localparam int kDivZero = 14;
    localparam int kInvalid = 15;
    localparam int kAddOvf = 16;
    localparam int kJr = 17;

    localparam int fetchLimit = 60;
    localparam int decodeLimit = 8;

    localparam int aluKinds [7] = '{kAdd, kSub, kAnd, kSlt, kAddi, kMfhi, kMflo};
    // beq and lb first and then other dropped codes as {opcode, funct}
    localparam logic [11:0] badCodes [10] = '{
        {6'd4, 6'd0}, {6'd32, 6'd0}, {6'd5, 6'd0}, {6'd40, 6'd0}, {6'd2, 6'd0},
        {6'd3, 6'd0}, {6'd10, 6'd0}, {6'd0, 6'd37}, {6'd0, 6'd2}, {6'd0, 6'd13}
    };

    logic clk;
    logic reset;
    logic [5:0] opcode;
    logic [5:0] funct;
    logic aluOverflow;
    logic multOverflow;
    logic divByZero;

    logic memWrite;
    logic pcWrite;
    logic memRead;
    logic irWrite;
    logic regWrite;
    logic aluSrcA;
    logic epcWrite;
    logic iorD;
    logic hiWrite;
    logic loWrite;
    logic divMult;
    logic aluOutWrite;
    logic exceptionOcurred;
    logic [`SEL_W-1:0] memToReg;
    logic [`SEL_W-1:0] regDest;
    logic [`SEL_W-1:0] writeSrc;
    logic [`SEL_W-1:0] pcSource;
    logic [`SEL_W-1:0] aluSrcB;
    logic [`SEL_W-1:0] shiftSourceA;
    logic [`SEL_W-1:0] shiftSourceB;
    ctrlPkg::aluOp aluControl;
    ctrlPkg::shiftOp shiftControl;
    ctrlPkg::excCause exception;

    int kind;
    int errorCount;
    int testCount;
    int unsigned lcgState;

    // Expected responses for the current kind
    logic aluKind;
    logic shiftKind;
    logic resetOuts;
    logic [`SEL_W-1:0] expDest;
    ctrlPkg::aluOp expAlu;
    ctrlPkg::shiftOp expShift;
    ctrlPkg::excCause expCause;

    controlUnit u_controlUnit (
        .clk              (clk),
        .reset            (reset),
        .opcode           (opcode),
        .funct            (funct),
        .aluOverflow      (aluOverflow),
        .multOverflow     (multOverflow),
        .divByZero        (divByZero),
        .MemWrite         (memWrite),
        .PCWrite          (pcWrite),
        .MemRead          (memRead),
        .IRWrite          (irWrite),
        .RegWrite         (regWrite),
        .ALUSrcA          (aluSrcA),
        .EPCWrite         (epcWrite),
        .IorD             (iorD),
        .HIWrite          (hiWrite),
        .LOWrite          (loWrite),
        .DivMult          (divMult),
        .ALUoutWrite      (aluOutWrite),
        .ExceptionOcurred (exceptionOcurred),
        .MemToReg         (memToReg),
        .RegDest          (regDest),
        .WriteSrc         (writeSrc),
        .PCSource         (pcSource),
        .ALUSrcB          (aluSrcB),
        .ShiftSourceA     (shiftSourceA),
        .ShiftSourceB     (shiftSourceB),
        .ALUControl       (aluControl),
        .ShiftControl     (shiftControl),
        .Exception        (exception)
    );

    always #50 clk = ~clk;

    // R-type ALU results go to rd, addi to rt
    assign aluKind = kind inside {kAdd, kSub, kAnd, kSlt, kAddi, kMfhi, kMflo};
    assign expDest = (kind == kAddi) ? 4'd0 : 4'd1;
    assign expAlu = (kind == kAdd || kind == kAddi) ? ctrlPkg::aluAdd :
                    (kind == kSub) ? ctrlPkg::aluSub :
                    (kind == kAnd) ? ctrlPkg::aluAnd :
                    (kind == kSlt) ? ctrlPkg::aluCmp : ctrlPkg::aluLoad;
    // lui shifts its immediate left like sll
    assign shiftKind = kind inside {kSll, kSra, kLui};
    assign expShift = (kind == kSra) ? ctrlPkg::shRightArith : ctrlPkg::shLeft;
    assign expCause = (kind == kInvalid) ? ctrlPkg::excInvalidOp :
                      (kind == kAddOvf) ? ctrlPkg::excOverflow : ctrlPkg::excDivByZero;
    // Boot write of register 29 with all other outputs low
    assign resetOuts = regWrite && regDest == 4'd3 && memToReg == 4'd2
        && !memRead && !memWrite && !pcWrite && !irWrite && !aluSrcA && !epcWrite
        && !iorD && !hiWrite && !loWrite && !divMult && !aluOutWrite && !exceptionOcurred
        && writeSrc == '0 && pcSource == '0 && aluSrcB == '0
        && shiftSourceA == '0 && shiftSourceB == '0
        && aluControl == ctrlPkg::aluLoad && shiftControl == ctrlPkg::shIdle
        && exception == ctrlPkg::excNone;

    task automatic reportError(input string msg);
        errorCount++;
        $display("Error at time %0t: %s", $time, msg);
    endtask

    task automatic endTest(input string name);
        testCount++;
        $display("Test %0d (%s) finished, errors so far %0d", testCount, name, errorCount);
    endtask

    task automatic finishRun();
        $display("Tests run: %0d, errors: %0d", testCount, errorCount);
        if (errorCount == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    endtask

    function automatic int unsigned randBelow(input int unsigned n);
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return (lcgState >> 16) % n;
    endfunction

    function automatic logic [11:0] encodeKind(input int k);
        case (k)
            kAdd, kAddOvf: return {`OP_RTYPE, `FN_ADD};
            kSub:          return {`OP_RTYPE, `FN_SUB};
            kAnd:          return {`OP_RTYPE, `FN_AND};
            kSlt:          return {`OP_RTYPE, `FN_SLT};
            kMfhi:         return {`OP_RTYPE, `FN_MFHI};
            kMflo:         return {`OP_RTYPE, `FN_MFLO};
            kJr:           return {`OP_RTYPE, `FN_JR};
            kSll:          return {`OP_RTYPE, `FN_SLL};
            kSra:          return {`OP_RTYPE, `FN_SRA};
            kMult:         return {`OP_RTYPE, `FN_MULT};
            kDivm:         return {`OP_RTYPE, `FN_DIVM};
            kDivZero:      return {`OP_RTYPE, `FN_DIV};
            kAddi:         return {`OP_ADDI, 6'd0};
            kLui:          return {`OP_LUI, 6'd0};
            kLw:           return {`OP_LW, 6'd0};
            kSw:           return {`OP_SW, 6'd0};
            default:       return badCodes[0];
        endcase
    endfunction

    task automatic waitFetch();
        int cycles;
        cycles = 0;
        while (!memRead && cycles < fetchLimit)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!memRead)
        begin
            $display("Timeout: no instruction fetch within %0d cycles", fetchLimit);
            errorCount++;
        end
    endtask

    task automatic waitDecode();
        int cycles;
        cycles = 0;
        while (!irWrite && cycles < decodeLimit)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!irWrite)
        begin
            $display("Timeout: no decode cycle within %0d cycles", decodeLimit);
            errorCount++;
        end
    endtask

    // New IR contents during the first fetch cycle
    task automatic issueInstr(input int k, input logic [11:0] code);
        waitFetch();
        kind = k;
        opcode = code[11:6];
        funct = code[5:0];
        waitDecode();
    endtask

    // Two reset cycles, fetch, increment, decode
    assert property (@(posedge clk) disable iff (reset)
        $fell(reset) |-> resetOuts [*2] ##1 memRead [*2]
            ##1 (pcWrite && aluControl == ctrlPkg::aluAdd) ##1 irWrite)
        else reportError("reset sequence wrong");

    assert property (@(posedge clk) disable iff (reset)
        $rose(memRead) |=> memRead ##1 (pcWrite && aluControl == ctrlPkg::aluAdd) ##1 irWrite)
        else reportError("fetch, increment, decode order wrong");

    assert property (@(posedge clk) disable iff (reset)
        irWrite && aluKind |=> (!regWrite && aluControl == expAlu)
            ##1 (regWrite && regDest == expDest) ##1 memRead)
        else reportError("ALU op or write-back wrong");

    assert property (@(posedge clk) disable iff (reset)
        irWrite && shiftKind |=> (shiftControl == ctrlPkg::shLoad) [*2]
            ##1 (shiftControl == expShift) [*2] ##1 regWrite ##1 memRead)
        else reportError("shift sequence wrong");

    // Address calc, memory read, then load write-back
    assert property (@(posedge clk) disable iff (reset)
        irWrite && kind == kLw |=> (!iorD && aluControl == ctrlPkg::aluAdd)
            ##1 (iorD && !regWrite) [*2] ##1 (iorD && regWrite && memToReg == 4'd1) [*2]
            ##1 memRead)
        else reportError("lw sequence wrong");

    assert property (@(posedge clk) disable iff (reset)
        irWrite && kind == kSw |=> (!iorD && !memWrite) ##1 (memWrite && iorD) ##1 memRead)
        else reportError("sw sequence wrong");

    assert property (@(posedge clk) disable iff (reset)
        irWrite && kind == kMult |=> (hiWrite && loWrite && divMult) [*34] ##1 memRead)
        else reportError("mult sequence wrong");

    assert property (@(posedge clk) disable iff (reset)
        irWrite && kind == kDivm |=> (!memRead && !epcWrite) [*34] ##1 memRead)
        else reportError("divm length wrong");

    assert property (@(posedge clk) disable iff (reset)
        irWrite && kind == kDivZero |=> (hiWrite && loWrite && !divMult))
        else reportError("div execute wrong");

    // Zero divisor aborts on the next edge
    assert property (@(posedge clk) disable iff (reset)
        hiWrite && !divMult && divByZero |=> epcWrite && exception == ctrlPkg::excDivByZero)
        else reportError("divide by zero trap missing");

    assert property (@(posedge clk) disable iff (reset)
        irWrite && kind == kInvalid |=> epcWrite && exception == ctrlPkg::excInvalidOp)
        else reportError("invalid opcode trap missing");

    assert property (@(posedge clk) disable iff (reset)
        irWrite && kind == kAddOvf |=> (aluControl == ctrlPkg::aluAdd && aluOverflow)
            ##1 (epcWrite && exception == ctrlPkg::excOverflow))
        else reportError("overflow trap missing");

    assert property (@(posedge clk) disable iff (reset)
        irWrite && kind == kJr |=> (pcWrite && pcSource == 4'd1) [*2] ##1 memRead)
        else reportError("jr sequence wrong");

    // Cause held 6 cycles and then 2 vector cycles
    assert property (@(posedge clk) disable iff (reset)
        $rose(epcWrite) |-> (epcWrite && exception == expCause) [*6]
            ##1 (exceptionOcurred && pcWrite && pcSource == 4'd3) [*2] ##1 memRead)
        else reportError("exception sequence wrong");

    initial
    begin
        int i;
        int k;
        int n;
        clk = 1'b0;
        reset = 1'b1;
        opcode = `OP_RTYPE;
        funct = `FN_ADD;
        aluOverflow = 1'b0;
        multOverflow = 1'b0;
        divByZero = 1'b0;
        kind = kAdd;
        errorCount = 0;
        testCount = 0;
        lcgState = 32'd86386;
        repeat (2) @(negedge clk);
        reset = 1'b0;

        waitDecode();
        endTest("reset and first fetch");

        for (i = 0; i < 14; i++)
        begin
            k = aluKinds[randBelow(7)];
            issueInstr(k, encodeKind(k));
        end
        endTest("random ALU ops");

        issueInstr(kSll, encodeKind(kSll));
        issueInstr(kSra, encodeKind(kSra));
        issueInstr(kLui, encodeKind(kLui));
        issueInstr(kLw, encodeKind(kLw));
        issueInstr(kSw, encodeKind(kSw));
        endTest("shifts, lui, lw, sw");

        issueInstr(kMult, encodeKind(kMult));
        issueInstr(kDivm, encodeKind(kDivm));
        issueInstr(kDivZero, encodeKind(kDivZero));
        // Zero divisor part way into the run
        n = 2 + randBelow(20);
        repeat (n) @(negedge clk);
        divByZero = 1'b1;
        @(negedge clk);
        divByZero = 1'b0;
        endTest("mult, divm, div by zero");

        for (i = 0; i < 8; i++)
        begin
            n = (i < 2) ? i : randBelow(10);
            issueInstr(kInvalid, badCodes[n]);
        end
        endTest("invalid opcodes");

        issueInstr(kAddOvf, encodeKind(kAddOvf));
        // Overflow flag in the add execute cycle
        @(negedge clk);
        aluOverflow = 1'b1;
        @(negedge clk);
        aluOverflow = 1'b0;
        issueInstr(kJr, encodeKind(kJr));
        waitFetch();
        repeat (2) @(negedge clk);
        endTest("overflow and jr");

        finishRun();
    end

endmodule

`default_nettype wire
